//--- hw/gf64_shift_reduce.sv
// Constant power-of-two multiply mod p with fold back below 2^65, one register stage
`include "ntt_gf64_defs.svh"

`default_nettype none

module gf64_shift_reduce #(
  // Twiddle exponent, 0 to 95
  parameter int SHIFT = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  ntt_gf64_pkg::op_t   in_op,
  output logic                out_valid,
  output ntt_gf64_pkg::op_t   out_op
);

  // --------------------------------------------------
  // Valid pipe
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  if (SHIFT == 0) begin : g_bypass
    // Twiddle is 1, register only
    always_ff @(posedge clk) begin
      out_op <= in_op;
    end
  end else begin : g_fold
    // Operand below 2^65, shift below 2^96, so product fits 162 bits
    localparam int PROD_W = `NTT_OP_W + 96;
    localparam logic [66:0] TWO_P = {2'b00, `NTT_PRIME, 1'b0};

    logic [PROD_W-1:0] prod;
    logic [66:0]       fold_t;
    logic [66:0]       fold_hi;
    logic [66:0]       fold_r;

    assign prod = {{(PROD_W-`NTT_OP_W){1'b0}}, in_op} << SHIFT;

    // prod = lo + mid*2^64 + hi*2^96
    // 2^64 = 2^32 - 1 and 2^96 = -1 mod p
    always_comb begin
      // lo + mid*(2^32 - 1), below 2^65
      fold_t = {3'b000, prod[63:0]}
             + {3'b000, prod[95:64], 32'h0000_0000}
             - {35'h0, prod[95:64]};
      // hi is below 2^64 for every legal SHIFT
      fold_hi = {1'b0, prod[PROD_W-1:96]};
      // Negative difference lifted by 2p, stays below 2^65
      if (fold_t >= fold_hi) begin
        fold_r = fold_t - fold_hi;
      end else begin
        fold_r = fold_t - fold_hi + TWO_P;
      end
    end

    always_ff @(posedge clk) begin
      out_op <= fold_r[`NTT_OP_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- hw/ntt_gf64_butterfly.sv
// Radix-2 Cooley-Tukey butterfly over GF64 with power-of-two twiddle, partial reduction
`include "ntt_gf64_defs.svh"

`default_nettype none

module ntt_gf64_butterfly #(
  // Twiddle exponent handed to the shift unit
  parameter int SHIFT = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  ntt_gf64_pkg::op_t   a,
  input  ntt_gf64_pkg::op_t   b,
  output logic                out_valid,
  output ntt_gf64_pkg::op_t   z_add,
  output ntt_gf64_pkg::op_t   z_sub
);

  // Signed 68-bit view covers sum and difference of two 2^65 operands
  localparam logic signed [67:0] P_S     = {4'h0, `NTT_PRIME};
  localparam logic signed [67:0] TWO_P_S = {3'b000, `NTT_PRIME, 1'b0};
  localparam logic signed [67:0] LIM_S   = 68'sh2_0000_0000_0000_0000;

  // Bring v from (-2^65, 2^66) back into [0, 2^65)
  function automatic ntt_gf64_pkg::op_t fold_op(input logic signed [67:0] v);
    logic signed [67:0] r;
    if (v < 0) begin
      r = v + TWO_P_S;
      if (r < 0) begin
        r = r + P_S;
      end
    end else if (v >= LIM_S) begin
      r = v - TWO_P_S;
      if (r >= LIM_S) begin
        r = r - P_S;
      end
    end else begin
      r = v;
    end
    return r[`NTT_OP_W-1:0];
  endfunction

  // --------------------------------------------------
  // Cycle 1: twiddle on b, a delayed alongside
  // --------------------------------------------------
  logic              sh_valid;
  ntt_gf64_pkg::op_t b_sh;
  ntt_gf64_pkg::op_t a_q;

  gf64_shift_reduce #(
    .SHIFT     (SHIFT)
  ) i_shift (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (b),
    .out_valid (sh_valid),
    .out_op    (b_sh)
  );

  always_ff @(posedge clk) begin
    a_q <= a;
  end

  // --------------------------------------------------
  // Cycle 2: add and subtract
  // --------------------------------------------------
  logic signed [67:0] sum_s;
  logic signed [67:0] diff_s;

  always_comb begin
    sum_s  = $signed({2'b00, a_q}) + $signed({2'b00, b_sh});
    // May go negative, fold_op adds p multiples back
    diff_s = $signed({2'b00, a_q}) - $signed({2'b00, b_sh});
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sh_valid;
    end
  end

  always_ff @(posedge clk) begin
    z_add <= fold_op(sum_s);
    z_sub <= fold_op(diff_s);
  end

endmodule

`default_nettype wire

//--- hw/ntt_gf64_defs.svh
// Goldilocks 8-point NTT constants: sizes, operand widths and the prime
`ifndef NTT_GF64_DEFS_SVH
`define NTT_GF64_DEFS_SVH

// --------------------------------------------------
// Transform geometry
// --------------------------------------------------
// Points per vector
`define NTT_N 8
// Radix-2 stage columns, log2 of NTT_N
`define NTT_STG_NB 3

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
// Canonical coefficient, value in [0, p)
`define NTT_COEF_W 64
// Partially reduced operand, value kept below 2^65
`define NTT_OP_W 66
// Side tag carried next to each vector
`define NTT_TAG_W 8

// --------------------------------------------------
// Field constants
// --------------------------------------------------
// p = 2^64 - 2^32 + 1
`define NTT_PRIME 64'hFFFF_FFFF_0000_0001
// w = 2^24, order 8 since 2^96 = -1 mod p
`define NTT_OMG_LOG 24

`endif

//--- hw/ntt_gf64_final_reduce.sv
// Canonical reduction of eight partially reduced lanes into [0, p), registered
`include "ntt_gf64_defs.svh"

`default_nettype none

module ntt_gf64_final_reduce (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  ntt_gf64_pkg::op_vec_t     in_data,
  output logic                      out_valid,
  output ntt_gf64_pkg::coef_vec_t   out_data,
  input  ntt_gf64_pkg::tag_t        in_tag,
  output ntt_gf64_pkg::tag_t        out_tag
);

  localparam logic [`NTT_OP_W-1:0] P_OP = {2'b00, `NTT_PRIME};

  ntt_gf64_pkg::op_t      fold_v [`NTT_N];
  ntt_gf64_pkg::coef_vec_t canon;

  // --------------------------------------------------
  // Per-lane reduction
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < `NTT_N; i++) begin
      // Bit 64 set: drop 2^64, add 2^32 - 1, same as minus p
      if (in_data.lane[i][`NTT_COEF_W]) begin
        fold_v[i] = in_data.lane[i] - P_OP;
      end else begin
        fold_v[i] = in_data.lane[i];
      end
      // Now below 2p
      if (fold_v[i] >= P_OP) begin
        canon.lane[i] = ntt_gf64_pkg::coef_t'(fold_v[i] - P_OP);
      end else begin
        canon.lane[i] = ntt_gf64_pkg::coef_t'(fold_v[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_data <= canon;
    out_tag  <= in_tag;
  end

endmodule

`default_nettype wire

//--- hw/ntt_gf64_fwd8.sv
// Fully pipelined 8-point forward NTT over GF64, natural order in and out
`include "ntt_gf64_defs.svh"

`default_nettype none

module ntt_gf64_fwd8 (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  ntt_gf64_pkg::coef_vec_t   in_coef,
  input  ntt_gf64_pkg::tag_t        in_tag,
  output logic                      out_valid,
  output ntt_gf64_pkg::coef_vec_t   out_coef,
  output ntt_gf64_pkg::tag_t        out_tag
);

  // Reverse the low NTT_STG_NB bits of idx
  function automatic int bit_rev(input int idx);
    int r;
    r = 0;
    for (int b = 0; b < `NTT_STG_NB; b++) begin
      r = (r << 1) | ((idx >> b) & 1);
    end
    return r;
  endfunction

  // Link k feeds column k, last link feeds the final reduction
  logic                  link_valid [`NTT_STG_NB+1];
  ntt_gf64_pkg::op_vec_t link_data  [`NTT_STG_NB+1];
  ntt_gf64_pkg::tag_t    link_tag   [`NTT_STG_NB+1];
  ntt_gf64_pkg::op_vec_t rev_data;

  // --------------------------------------------------
  // Bit-reversal wiring, zero extension to operand width
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < `NTT_N; i++) begin
      rev_data.lane[i] = {{(`NTT_OP_W-`NTT_COEF_W){1'b0}}, in_coef.lane[bit_rev(i)]};
    end
  end

  assign link_valid[0] = in_valid;
  assign link_data[0]  = rev_data;
  assign link_tag[0]   = in_tag;

  // --------------------------------------------------
  // Stage columns, 2 cycles each
  // --------------------------------------------------
  for (genvar gs = 0; gs < `NTT_STG_NB; gs++) begin : g_stg
    ntt_gf64_stage_column #(
      .STG_ID    (gs)
    ) i_col (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (link_valid[gs]),
      .in_data   (link_data[gs]),
      .in_tag    (link_tag[gs]),
      .out_valid (link_valid[gs+1]),
      .out_data  (link_data[gs+1]),
      .out_tag   (link_tag[gs+1])
    );
  end

  // Canonical output, 1 cycle
  ntt_gf64_final_reduce i_final (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (link_valid[`NTT_STG_NB]),
    .in_data   (link_data[`NTT_STG_NB]),
    .out_valid (out_valid),
    .out_data  (out_coef),
    .in_tag    (link_tag[`NTT_STG_NB]),
    .out_tag   (out_tag)
  );

endmodule

`default_nettype wire

//--- hw/ntt_gf64_pkg.sv
// Shared packed types for the GF64 forward NTT datapath
`include "ntt_gf64_defs.svh"

`default_nettype none

package ntt_gf64_pkg;

  // --------------------------------------------------
  // Scalars
  // --------------------------------------------------
  // Operand inside the pipeline
  // Congruent to its value mod p, always below 2^65
  typedef logic [`NTT_OP_W-1:0] op_t;

  // Canonical field element, [0, p)
  typedef logic [`NTT_COEF_W-1:0] coef_t;

  // Per-vector side information
  // Travels with the data, never modified
  typedef logic [`NTT_TAG_W-1:0] tag_t;

  // --------------------------------------------------
  // Vectors
  // --------------------------------------------------
  // Datapath between stage columns
  // Lane i is point i of the current ordering
  typedef struct packed {
    op_t [`NTT_N-1:0] lane;
  } op_vec_t;

  // Top-level input and output vector
  // Natural order on both sides
  typedef struct packed {
    coef_t [`NTT_N-1:0] lane;
  } coef_vec_t;

endpackage

`default_nettype wire

//--- hw/ntt_gf64_stage_column.sv
// One Rev->Nat NTT stage column: lane pairing, four butterflies, tag delay
`include "ntt_gf64_defs.svh"

`default_nettype none

module ntt_gf64_stage_column #(
  // Stage number, 0 to 2
  parameter int STG_ID = 0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  ntt_gf64_pkg::op_vec_t   in_data,
  input  ntt_gf64_pkg::tag_t      in_tag,
  output logic                    out_valid,
  output ntt_gf64_pkg::op_vec_t   out_data,
  output ntt_gf64_pkg::tag_t      out_tag
);

  localparam int SPAN  = 1 << STG_ID;
  localparam int BU_NB = `NTT_N / 2;

  // Lower lane of butterfly bi: group base plus offset in group
  function automatic int lane_a_idx(input int bi);
    return (bi / SPAN) * 2 * SPAN + (bi % SPAN);
  endfunction

  // Butterfly feeding lane l
  function automatic int bu_of_lane(input int l);
    return (l / (2 * SPAN)) * SPAN + (l % SPAN);
  endfunction

  // w^(j * 2^(2-s)) with w = 2^24
  function automatic int bu_shift(input int bi);
    return `NTT_OMG_LOG * (bi % SPAN) * (1 << (`NTT_STG_NB - 1 - STG_ID));
  endfunction

  ntt_gf64_pkg::op_t bu_a   [BU_NB];
  ntt_gf64_pkg::op_t bu_b   [BU_NB];
  ntt_gf64_pkg::op_t bu_add [BU_NB];
  ntt_gf64_pkg::op_t bu_sub [BU_NB];

  // --------------------------------------------------
  // Input network
  // --------------------------------------------------
  always_comb begin
    for (int bi = 0; bi < BU_NB; bi++) begin
      bu_a[bi] = in_data.lane[lane_a_idx(bi)];
      bu_b[bi] = in_data.lane[lane_a_idx(bi) + SPAN];
    end
  end

  // --------------------------------------------------
  // Butterflies
  // --------------------------------------------------
  for (genvar gi = 0; gi < BU_NB; gi++) begin : g_bu
    localparam int BU_SHIFT = bu_shift(gi);

    if (gi == 0) begin : g_lead
      // All butterflies run in lockstep, this one drives the column valid
      ntt_gf64_butterfly #(
        .SHIFT     (BU_SHIFT)
      ) i_bu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (bu_a[gi]),
        .b         (bu_b[gi]),
        .out_valid (out_valid),
        .z_add     (bu_add[gi]),
        .z_sub     (bu_sub[gi])
      );
    end else begin : g_rest
      ntt_gf64_butterfly #(
        .SHIFT     (BU_SHIFT)
      ) i_bu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (bu_a[gi]),
        .b         (bu_b[gi]),
        .out_valid (),
        .z_add     (bu_add[gi]),
        .z_sub     (bu_sub[gi])
      );
    end
  end

  // --------------------------------------------------
  // Output network
  // --------------------------------------------------
  // Bit STG_ID of the lane index picks the upper (difference) output
  always_comb begin
    for (int l = 0; l < `NTT_N; l++) begin
      if (((l / SPAN) % 2) == 1) begin
        out_data.lane[l] = bu_sub[bu_of_lane(l)];
      end else begin
        out_data.lane[l] = bu_add[bu_of_lane(l)];
      end
    end
  end

  // Tag follows the two butterfly cycles
  ntt_gf64_pkg::tag_t tag_q;

  always_ff @(posedge clk) begin
    tag_q   <= in_tag;
    out_tag <= tag_q;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/ntt_gf64_pkg.sv
hw/gf64_shift_reduce.sv
hw/ntt_gf64_butterfly.sv
hw/ntt_gf64_stage_column.sv
hw/ntt_gf64_final_reduce.sv
hw/ntt_gf64_fwd8.sv
testbench/tb_ntt_gf64_fwd8.sv

//--- testbench/tb_ntt_gf64_fwd8.sv
// Directed testbench for the pipelined 8-point GF64 forward NTT with a software model
`include "ntt_gf64_defs.svh"

`default_nettype none

module tb_ntt_gf64_fwd8;

  localparam logic [63:0] P        = `NTT_PRIME;
  localparam int          LATENCY  = 7;
  localparam int          WAIT_MAX = 20;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    in_valid;
  ntt_gf64_pkg::coef_vec_t in_coef;
  ntt_gf64_pkg::tag_t      in_tag;
  logic                    out_valid;
  ntt_gf64_pkg::coef_vec_t out_coef;
  ntt_gf64_pkg::tag_t      out_tag;

  // Cycle stamp, advanced on every rising edge
  int          cyc = 0;
  logic [31:0] rng_state = 32'h9ac6eace;

  // Vectors in flight, oldest first
  ntt_gf64_pkg::coef_vec_t exp_vec_q [$];
  ntt_gf64_pkg::tag_t      exp_tag_q [$];
  int                      exp_cyc_q [$];
  ntt_gf64_pkg::coef_vec_t mon_vec;
  ntt_gf64_pkg::tag_t      mon_tag;
  int                      mon_cyc;

  ntt_gf64_fwd8 i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_coef   (in_coef),
    .in_tag    (in_tag),
    .out_valid (out_valid),
    .out_coef  (out_coef),
    .out_tag   (out_tag)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------------------------------------
  // Field arithmetic and reference model
  // --------------------------------------------------
  function automatic logic [63:0] mulmod(input logic [63:0] a, input logic [63:0] b);
    logic [127:0] prod;
    prod = {64'h0, a} * {64'h0, b};
    return 64'(prod % {64'h0, P});
  endfunction

  // Both operands already below p
  function automatic logic [63:0] addmod(input logic [63:0] a, input logic [63:0] b);
    logic [64:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, P}) begin
      s = s - {1'b0, P};
    end
    return s[63:0];
  endfunction

  // 2^e mod p by repeated doubling
  function automatic logic [63:0] pow2_mod(input int e);
    logic [63:0] r;
    r = 64'd1;
    for (int i = 0; i < e; i++) begin
      r = addmod(r, r);
    end
    return r;
  endfunction

  // X[k] = sum of x[n] * w^(n*k) mod p, w = 2^24
  function automatic ntt_gf64_pkg::coef_vec_t ntt_model(input ntt_gf64_pkg::coef_vec_t x);
    ntt_gf64_pkg::coef_vec_t y;
    logic [63:0]             wk;
    logic [63:0]             tw;
    logic [63:0]             acc;
    for (int k = 0; k < `NTT_N; k++) begin
      wk  = pow2_mod(`NTT_OMG_LOG * k);
      tw  = 64'd1;
      acc = 64'd0;
      for (int n = 0; n < `NTT_N; n++) begin
        acc = addmod(acc, mulmod(x.lane[n], tw));
        // Step to w^((n+1)*k)
        tw  = mulmod(tw, wk);
      end
      y.lane[k] = acc;
    end
    return y;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Eight lanes, each below p
  task automatic random_vec(output ntt_gf64_pkg::coef_vec_t v);
    logic [63:0] r;
    for (int i = 0; i < `NTT_N; i++) begin
      rng_state = xorshift32(rng_state);
      r[63:32]  = rng_state;
      rng_state = xorshift32(rng_state);
      r[31:0]   = rng_state;
      // Rare draws at or above p wrap into range
      if (r >= P) begin
        r = r - P;
      end
      v.lane[i] = r;
    end
  endtask

  // --------------------------------------------------
  // Failure reporting and compares
  // --------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_coef_vec(input string name, input ntt_gf64_pkg::coef_vec_t got,
                                  input ntt_gf64_pkg::coef_vec_t want);
    for (int i = 0; i < `NTT_N; i++) begin
      if (got.lane[i] !== want.lane[i]) begin
        abort_run($sformatf("error t=%0t %s.lane[%0d] got %h expected %h",
                            $time, name, i, got.lane[i], want.lane[i]));
      end
    end
  endtask

  task automatic compare_tag(input string name, input ntt_gf64_pkg::tag_t got,
                             input ntt_gf64_pkg::tag_t want);
    if (got !== want) begin
      abort_run($sformatf("error t=%0t %s got %h expected %h", $time, name, got, want));
    end
  endtask

  // --------------------------------------------------
  // Monitor, sampled mid-cycle
  // --------------------------------------------------
  // Model result, tag and latency of every output
  always @(negedge clk) begin
    if (rst) begin
      // Reset drops everything in flight
      exp_vec_q.delete();
      exp_tag_q.delete();
      exp_cyc_q.delete();
    end else begin
      if (in_valid) begin
        exp_vec_q.push_back(ntt_model(in_coef));
        exp_tag_q.push_back(in_tag);
        exp_cyc_q.push_back(cyc);
      end
      if (out_valid) begin
        if (exp_vec_q.size() == 0) begin
          abort_run("out_valid asserted with no vector in flight");
        end else begin
          mon_vec = exp_vec_q.pop_front();
          mon_tag = exp_tag_q.pop_front();
          mon_cyc = exp_cyc_q.pop_front();
          compare_coef_vec("out_coef", out_coef, mon_vec);
          compare_tag("out_tag", out_tag, mon_tag);
          if (cyc - mon_cyc != LATENCY) begin
            abort_run($sformatf("error t=%0t out_valid latency got %0d expected %0d",
                                $time, cyc - mon_cyc, LATENCY));
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Drive and wait helpers
  // --------------------------------------------------
  task automatic drive_vec(input ntt_gf64_pkg::coef_vec_t v, input ntt_gf64_pkg::tag_t t);
    @(posedge clk);
    in_valid <= 1'b1;
    in_coef  <= v;
    in_tag   <= t;
  endtask

  task automatic release_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst      <= 1'b1;
    in_valid <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_output(output ntt_gf64_pkg::coef_vec_t got,
                             output ntt_gf64_pkg::tag_t got_tag);
    int n;
    bit seen;
    seen = 1'b0;
    n    = 0;
    while (!seen) begin
      if (n == WAIT_MAX) begin
        abort_run("timeout: no out_valid within 20 cycles");
      end else begin
        @(negedge clk);
        n++;
        if (out_valid === 1'b1) begin
          seen    = 1'b1;
          got     = out_coef;
          got_tag = out_tag;
        end
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_vec_q.size() != 0) begin
      if (n == WAIT_MAX) begin
        abort_run("timeout: vectors still in flight after 20 cycles");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        abort_run("out_valid was not low while the pipeline was idle");
      end
    end
  endtask

  // One vector through the pipe, checked against want
  task automatic run_one(input ntt_gf64_pkg::coef_vec_t v, input ntt_gf64_pkg::tag_t t,
                         input ntt_gf64_pkg::coef_vec_t want);
    ntt_gf64_pkg::coef_vec_t got;
    ntt_gf64_pkg::tag_t      got_tag;
    drive_vec(v, t);
    release_input();
    wait_output(got, got_tag);
    compare_coef_vec("out_coef", got, want);
    compare_tag("out_tag", got_tag, t);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  // Quiet after reset, then impulse and shifted impulse
  task automatic test_idle_and_basis();
    ntt_gf64_pkg::coef_vec_t v;
    ntt_gf64_pkg::coef_vec_t want;
    check_idle(10);
    v = '0;
    v.lane[0] = 64'd1;
    for (int k = 0; k < `NTT_N; k++) begin
      want.lane[k] = 64'd1;
    end
    run_one(v, 8'h11, want);
    v = '0;
    v.lane[1] = 64'd1;
    // X[k] = w^k = 2^(24k)
    for (int k = 0; k < `NTT_N; k++) begin
      want.lane[k] = pow2_mod(`NTT_OMG_LOG * k);
    end
    run_one(v, 8'h12, want);
  endtask

  // Constant input: 8c in lane 0, zero elsewhere
  task automatic test_constant(input logic [63:0] c, input ntt_gf64_pkg::tag_t t);
    ntt_gf64_pkg::coef_vec_t v;
    ntt_gf64_pkg::coef_vec_t want;
    want = '0;
    for (int i = 0; i < `NTT_N; i++) begin
      v.lane[i] = c;
    end
    want.lane[0] = mulmod(64'd8, c);
    run_one(v, t, want);
  endtask

  task automatic test_random(input int count);
    ntt_gf64_pkg::coef_vec_t v;
    for (int i = 0; i < count; i++) begin
      random_vec(v);
      run_one(v, ntt_gf64_pkg::tag_t'(i), ntt_model(v));
    end
  endtask

  // One vector per cycle; the monitor checks order, tag and latency
  task automatic test_back_to_back(input int count);
    ntt_gf64_pkg::coef_vec_t v;
    for (int i = 0; i < count; i++) begin
      random_vec(v);
      drive_vec(v, ntt_gf64_pkg::tag_t'(i) ^ 8'hA5);
    end
    release_input();
    wait_drained();
  endtask

  // Reset mid-flight, then a fresh vector
  task automatic test_reset_in_flight();
    ntt_gf64_pkg::coef_vec_t v;
    for (int i = 0; i < 3; i++) begin
      random_vec(v);
      drive_vec(v, 8'hC0 + 8'(i));
    end
    release_input();
    repeat (2) @(posedge clk);
    apply_reset();
    check_idle(12);
    random_vec(v);
    run_one(v, 8'h3C, ntt_model(v));
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_coef  = '0;
    in_tag   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_idle_and_basis();
    // p - 1 and 2^63 edge values
    test_constant(P - 64'd1, 8'h21);
    test_constant(64'h8000_0000_0000_0000, 8'h22);
    test_random(100);
    test_back_to_back(50);
    test_reset_in_flight();
    wait_drained();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
